/* build.f */
design/host_if_pkg.sv
design/graph_pkg.sv
design/command_fifo.sv
design/vertex_job_reader.sv
design/cu_config_regs.sv
design/cu_control.sv
verification/tb_cu_control.sv

/* run.sh */
#!/bin/sh
# build and run the compute unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f build.f --top-module tb_cu_control

./obj_dir/Vtb_cu_control > sim.log 2>&1
cat sim.log

# result is decided by the log alone
if grep -qx "Everything OK" sim.log; then
	exit 0
fi
exit 1

/* verification/tb_cu_control.sv */
////////////////////
// cu_control testbench with a memory model, vertex jobs and result checks
// run through run.sh and ends with one count line and the verdict
////////////////////

`default_nettype none

module tb_cu_control;

	timeunit 1ns;
	timeprecision 100ps;

	import host_if_pkg::*;
	import graph_pkg::*;

	logic           clock;
	logic           rstn;
	logic           enabled_in;
	wed_t           wed_request_in;
	cu_config_t     cu_configure;
	data_line_t     read_data_in;
	buffer_status_t read_buffer_status;
	read_cmd_t      read_command_out;
	cu_return_t     cu_return;
	logic           cu_done;
	cu_config_t     cu_status;

	// bookkeeping
	int        checks;
	int        errors;
	int        timeouts;
	int        cycle;
	bit        inject_foreign;
	addr_t     job_base;
	degree_t   degrees [64];
	read_cmd_t cmd_log [$];
	read_cmd_t mem_cmds [$];
	int        mem_due [$];

	cu_control #(
		.CMD_BUFFER_DEPTH   (16),
		.CMD_BUFFER_HEADROOM(8 )
	) dut0 (
		.clock             (clock             ),
		.rstn              (rstn              ),
		.enabled_in        (enabled_in        ),
		.wed_request_in    (wed_request_in    ),
		.cu_configure      (cu_configure      ),
		.read_data_in      (read_data_in      ),
		.read_buffer_status(read_buffer_status),
		.read_command_out  (read_command_out  ),
		.cu_return         (cu_return         ),
		.cu_done           (cu_done           ),
		.cu_status         (cu_status         )
	);

	// 100 ns period
	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	////////////////////
	// helpers
	////////////////////
	task automatic step();
		@(posedge clock);
		#5;
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("ERROR %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("timeout while waiting for %s", what);
	endtask

	// some zero degrees so both vertex classes show up
	task automatic fill_degrees();
		for (int i = 0; i < 64; i++) begin
			if ($urandom % 4 == 0) begin
				degrees[i] = '0;
			end else begin
				degrees[i] = degree_t'(1 + $urandom % 100);
			end
		end
	endtask

	// expected line count, vertices seen and degree sum for n vertices
	function automatic void expected_totals(input int n, output int lines,
			output int vertices, output longint edges);
		int processed;
		int filtered;
		processed = 0;
		filtered  = 0;
		edges     = 0;
		lines     = (n + VERTICES_PER_LINE - 1) / VERTICES_PER_LINE;
		for (int i = 0; i < n; i++) begin
			if (degrees[i] != '0) begin
				processed++;
			end else begin
				filtered++;
			end
			edges += longint'(degrees[i]);
		end
		vertices = processed + filtered;
	endfunction

	////////////////////
	// memory model
	////////////////////
	// line index from the echoed address with lane 0 in the low bits
	function automatic data_line_t make_line(input read_cmd_t cmd);
		data_line_t line;
		int         first;
		line.valid = 1'b1;
		line.cmd   = cmd;
		line.data  = '0;
		first = int'((cmd.address - job_base) / 64'(LINE_BYTES)) * VERTICES_PER_LINE;
		for (int lane = 0; lane < VERTICES_PER_LINE; lane++) begin
			if (first + lane < 64) begin
				line.data[lane*16 +: 16] = degrees[first + lane];
			end
		end
		return line;
	endfunction

	// another unit's line would inflate every counter if accepted
	function automatic data_line_t foreign_line();
		data_line_t line;
		line.valid       = 1'b1;
		line.cmd.valid   = 1'b1;
		line.cmd.cu_id   = cu_id_t'(2 + $urandom % 200);
		line.cmd.address = job_base;
		line.cmd.size    = 8'(LINE_BYTES);
		line.data        = {8{16'h0101}};
		return line;
	endfunction

	// outputs sampled mid-cycle
	always @(negedge clock) begin
		cycle = cycle + 1;
		if (rstn && read_command_out.valid) begin
			cmd_log.push_back(read_command_out);
			mem_cmds.push_back(read_command_out);
			mem_due.push_back(cycle + 1 + int'($urandom % 6));
		end
	end

	// in-order returns of at most one line per cycle
	always @(posedge clock) begin
		#5;
		if (!rstn) begin
			mem_cmds.delete();
			mem_due.delete();
			read_data_in = '0;
		end else if (mem_cmds.size() > 0 && mem_due[0] <= cycle) begin
			read_data_in = make_line(mem_cmds.pop_front());
			void'(mem_due.pop_front());
		end else if (inject_foreign && ($urandom % 2 == 0)) begin
			read_data_in = foreign_line();
		end else begin
			read_data_in = '0;
		end
	end

	////////////////////
	// sequences
	////////////////////
	task automatic apply_reset();
		rstn               = 1'b0;
		enabled_in         = 1'b0;
		wed_request_in     = '0;
		cu_configure       = '0;
		inject_foreign     = 1'b0;
		read_buffer_status = '0;
		read_buffer_status.empty = 1'b1;
		repeat (16) step();
		rstn = 1'b1;
		step();
	endtask

	// one-cycle write and a wait for it on cu_status
	task automatic enable_and_configure(input string name, input cu_config_t value);
		int i;
		enabled_in = 1'b1;
		step();
		cu_configure = value;
		step();
		cu_configure = '0;
		for (i = 0; i < 10 && cu_status != value; i++) begin
			step();
		end
		if (cu_status != value) begin
			report_timeout({name, " configuration on cu_status"});
		end
		check_value({name, " status"}, value, cu_status);
	endtask

	// raise alfull once the first command is out
	task automatic hold_host_buffer(input string name);
		int i;
		int mark;
		for (i = 0; i < 50 && cmd_log.size() == 0; i++) begin
			step();
		end
		if (cmd_log.size() == 0) begin
			report_timeout({name, " first command"});
		end
		read_buffer_status.alfull = 1'b1;
		// a command already in the output register may still show
		step();
		mark = cmd_log.size();
		repeat (20) step();
		if (cmd_log.size() - mark > 1) begin
			errors++;
			$display("%s: %0d commands passed while the host buffer was almost full",
				name, cmd_log.size() - mark);
		end
		read_buffer_status.alfull = 1'b0;
	endtask

	task automatic run_job(input string name, input int n, input addr_t base,
			input int edge_extra, input bit foreign, input bit hold);
		int     lines;
		int     vertices;
		longint edges;
		bit     done_seen;
		int     i;
		apply_reset();
		fill_degrees();
		expected_totals(n, lines, vertices, edges);
		job_base = base;
		cmd_log.delete();
		enable_and_configure(name, 64'h0000_0000_0000_0001);
		inject_foreign = foreign;
		wed_request_in.valid        = 1'b1;
		wed_request_in.num_vertices = vertex_cnt_t'(n);
		wed_request_in.num_edges    = edge_cnt_t'(edges + longint'(edge_extra));
		wed_request_in.vertex_base  = base;
		if (hold) begin
			hold_host_buffer(name);
		end
		done_seen = 1'b0;
		for (i = 0; i < 400 && !done_seen; i++) begin
			step();
			done_seen = cu_done;
		end
		if (edge_extra != 0) begin
			// totals never match the descriptor
			check_value({name, " done stays low"}, 0, done_seen);
		end else begin
			if (!done_seen) begin
				report_timeout({name, " cu_done"});
			end
			check_value({name, " var1"}, 64'(vertices), cu_return.var1);
			check_value({name, " var2"}, 64'(edges), cu_return.var2);
			check_value({name, " cu_done"}, 1, cu_done);
		end
		// in order and once each
		check_value({name, " command count"}, 64'(lines), 64'(cmd_log.size()));
		for (i = 0; i < cmd_log.size(); i++) begin
			check_value({name, " address"}, base + addr_t'(i * LINE_BYTES),
				cmd_log[i].address);
			check_value({name, " cu_id"}, 64'd1, 64'(cmd_log[i].cu_id));
			check_value({name, " size"}, 64'(LINE_BYTES), 64'(cmd_log[i].size));
		end
		inject_foreign = 1'b0;
		wed_request_in = '0;
	endtask

	////////////////////
	// main sequence
	////////////////////
	initial begin
		void'($urandom(47));
		checks             = 0;
		errors             = 0;
		timeouts           = 0;
		cycle              = 0;
		job_base           = '0;
		inject_foreign     = 1'b0;
		rstn               = 1'b0;
		enabled_in         = 1'b0;
		wed_request_in     = '0;
		cu_configure       = '0;
		read_data_in       = '0;
		read_buffer_status = '0;

		// outputs cleared by reset
		apply_reset();
		check_value("reset command valid", 0, read_command_out.valid);
		check_value("reset cu_done", 0, cu_done);
		check_value("reset cu_status", 0, cu_status);
		check_value("reset cu_return", 0, cu_return.var1 | cu_return.var2);

		// a zero write leaves the latch alone
		enable_and_configure("configure", 64'h0000_0000_0000_1235);
		cu_configure = '0;
		repeat (5) step();
		check_value("zero write ignored", 64'h0000_0000_0000_1235, cu_status);

		run_job("three_lines", 21, 64'h0000_0000_0001_0000, 0, 1'b0, 1'b0);
		run_job("backpressure", 40, 64'h0000_0000_0002_0000, 0, 1'b0, 1'b1);
		run_job("foreign_ids", 29, 64'h0000_0000_0003_0040, 0, 1'b1, 1'b0);
		run_job("edge_mismatch", 16, 64'h0000_0000_0004_0000, 1, 1'b0, 1'b0);

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/cu_control.sv */
////////////////////
// compute unit top: config registers, vertex reader, command buffer
////////////////////

`default_nettype none

module cu_control #(
	parameter int CMD_BUFFER_DEPTH    = 16,
	parameter int CMD_BUFFER_HEADROOM = 8
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled_in,
	input  graph_pkg::wed_t             wed_request_in,
	input  graph_pkg::cu_config_t       cu_configure,
	input  host_if_pkg::data_line_t     read_data_in,
	input  host_if_pkg::buffer_status_t read_buffer_status,
	output host_if_pkg::read_cmd_t      read_command_out,
	output graph_pkg::cu_return_t       cu_return,
	output logic                        cu_done,
	output graph_pkg::cu_config_t       cu_status
);

	import host_if_pkg::*;
	import graph_pkg::*;

	logic           enabled;
	wed_t           wed;
	logic           job_start;
	logic           fifo_pop;
	read_cmd_t      cmd_push;
	read_cmd_t      fifo_out;
	buffer_status_t fifo_status;
	vertex_cnt_t    vertex_count;
	vertex_cnt_t    filtered_count;
	edge_cnt_t      edge_count;

	////////////////////
	// registers and outputs
	////////////////////
	cu_config_regs config_regs0 (
		.clock             (clock             ),
		.rstn              (rstn              ),
		.enabled_in        (enabled_in        ),
		.wed_request_in    (wed_request_in    ),
		.cu_configure      (cu_configure      ),
		.read_buffer_status(read_buffer_status),
		.fifo_out          (fifo_out          ),
		.fifo_empty        (fifo_status.empty ),
		.vertex_count      (vertex_count      ),
		.filtered_count    (filtered_count    ),
		.edge_count        (edge_count        ),
		.enabled           (enabled           ),
		.wed               (wed               ),
		.job_start         (job_start         ),
		.fifo_pop          (fifo_pop          ),
		.read_command_out  (read_command_out  ),
		.cu_return         (cu_return         ),
		.cu_done           (cu_done           ),
		.cu_status         (cu_status         )
	);

	////////////////////
	// vertex array reader
	////////////////////
	vertex_job_reader reader0 (
		.clock         (clock             ),
		.rstn          (rstn              ),
		.enabled       (enabled           ),
		.job_start     (job_start         ),
		.wed           (wed               ),
		.read_data_in  (read_data_in      ),
		.fifo_alfull   (fifo_status.alfull),
		.cmd_out       (cmd_push          ),
		.vertex_count  (vertex_count      ),
		.filtered_count(filtered_count    ),
		.edge_count    (edge_count        )
	);

	// commands wait here while the host buffer is almost full
	command_fifo #(
		.WIDTH   ($bits(read_cmd_t) ),
		.DEPTH   (CMD_BUFFER_DEPTH   ),
		.HEADROOM(CMD_BUFFER_HEADROOM)
	) cmd_fifo0 (
		.clock   (clock         ),
		.rstn    (rstn          ),
		.push    (cmd_push.valid),
		.data_in (cmd_push      ),
		.pop     (fifo_pop      ),
		.data_out(fifo_out      ),
		.status  (fifo_status   )
	);

endmodule

`default_nettype wire

/* design/cu_config_regs.sv */
////////////////////
// input latches, command output register, return words and done flag
////////////////////

`default_nettype none

module cu_config_regs (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled_in,
	input  graph_pkg::wed_t             wed_request_in,
	input  graph_pkg::cu_config_t       cu_configure,
	input  host_if_pkg::buffer_status_t read_buffer_status,
	input  host_if_pkg::read_cmd_t      fifo_out,
	input  logic                        fifo_empty,
	input  graph_pkg::vertex_cnt_t      vertex_count,
	input  graph_pkg::vertex_cnt_t      filtered_count,
	input  graph_pkg::edge_cnt_t        edge_count,
	output logic                        enabled,
	output graph_pkg::wed_t             wed,
	output logic                        job_start,
	output logic                        fifo_pop,
	output host_if_pkg::read_cmd_t      read_command_out,
	output graph_pkg::cu_return_t       cu_return,
	output logic                        cu_done,
	output graph_pkg::cu_config_t       cu_status
);

	import graph_pkg::*;

	cu_config_t  cfg_q;
	vertex_cnt_t vertex_snap;
	vertex_cnt_t filtered_snap;
	edge_cnt_t   edge_snap;
	cu_return_t  return_q;
	logic        done_q;

	////////////////////
	// inputs
	////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
			wed     <= '0;
			cfg_q   <= '0;
		end else begin
			enabled <= enabled_in;
			if (enabled) begin
				wed <= wed_request_in;
				// zero means no write this cycle
				if (|cu_configure) begin
					cfg_q <= cu_configure;
				end
			end
		end
	end

	// configured and holding a descriptor
	assign job_start = (|cfg_q) && wed.valid;

	// host back-pressure stops the pop directly
	assign fifo_pop = enabled && !fifo_empty && !read_buffer_status.alfull;

	////////////////////
	// results
	////////////////////
	// counter snapshots feed the compare
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_snap   <= '0;
			filtered_snap <= '0;
			edge_snap     <= '0;
		end else if (enabled) begin
			vertex_snap   <= vertex_count;
			filtered_snap <= filtered_count;
			edge_snap     <= edge_count;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			return_q <= '0;
			done_q   <= 1'b0;
		end else if (enabled && wed.valid) begin
			return_q.var1 <= 64'(vertex_snap + filtered_snap);
			return_q.var2 <= 64'(edge_snap);
			done_q <= (wed.num_vertices == vertex_snap + filtered_snap) &&
				(wed.num_edges == edge_snap);
		end
	end

	////////////////////
	// outputs
	////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_out <= '0;
			cu_return        <= '0;
			cu_done          <= 1'b0;
			cu_status        <= '0;
		end else if (enabled) begin
			// valid only in the cycle after a pop
			read_command_out <= fifo_pop ? fifo_out : '0;
			cu_return        <= return_q;
			// sticky until reset
			cu_done          <= cu_done || done_q;
			cu_status        <= cfg_q;
		end
	end

	a_done_sticky: assert property (@(posedge clock) disable iff (!rstn)
		cu_done |=> cu_done);

endmodule

`default_nettype wire

/* design/vertex_job_reader.sv */
////////////////////
// walks the vertex array one line at a time and tallies the returned
// out-degrees into processed, filtered and edge counters
////////////////////

`default_nettype none

module vertex_job_reader (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled,
	input  logic                    job_start,
	input  graph_pkg::wed_t         wed,
	input  host_if_pkg::data_line_t read_data_in,
	input  logic                    fifo_alfull,
	output host_if_pkg::read_cmd_t  cmd_out,
	output graph_pkg::vertex_cnt_t  vertex_count,
	output graph_pkg::vertex_cnt_t  filtered_count,
	output graph_pkg::edge_cnt_t    edge_count
);

	import host_if_pkg::*;
	import graph_pkg::*;

	localparam int LINE_SHIFT = $clog2(LINE_BYTES);
	localparam int VPL_SHIFT  = $clog2(VERTICES_PER_LINE);
	localparam int DEGREE_W   = $bits(degree_t);

	typedef enum logic [1:0] {
		idle,
		issue,
		wait_data
	} reader_state_t;

	reader_state_t state;
	vertex_cnt_t   num_lines;
	vertex_cnt_t   issue_idx;
	logic          issue_go;
	logic          last_issue;
	read_cmd_t     issue_cmd;

	data_line_t    data_q;
	logic          data_hit;
	addr_t         line_offset;
	vertex_cnt_t   first_vertex;
	degree_t       lane_degree;
	vertex_cnt_t   line_processed;
	vertex_cnt_t   line_filtered;
	edge_cnt_t     line_edges;

	////////////////////
	// command issue
	////////////////////
	// lines needed, rounded up
	assign num_lines = (wed.num_vertices + vertex_cnt_t'(VERTICES_PER_LINE - 1)) >> VPL_SHIFT;

	// one line per cycle while the buffer has room
	assign issue_go = enabled && job_start && !fifo_alfull &&
		(state == idle || state == issue) && (issue_idx < num_lines);
	assign last_issue = issue_go && ((issue_idx + 1'b1) == num_lines);

	always_comb begin
		issue_cmd.valid   = 1'b1;
		issue_cmd.cu_id   = VERTEX_CONTROL_ID;
		issue_cmd.address = wed.vertex_base + (addr_t'(issue_idx) << LINE_SHIFT);
		issue_cmd.size    = cmd_size_t'(LINE_BYTES);
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= idle;
			issue_idx <= '0;
			cmd_out   <= '0;
		end else begin
			cmd_out.valid <= 1'b0;
			if (issue_go) begin
				cmd_out   <= issue_cmd;
				issue_idx <= issue_idx + 1'b1;
			end
			case (state)
				idle: begin
					// first line leaves in the same cycle as the start
					if (enabled && job_start) begin
						state <= (last_issue || num_lines == '0) ? wait_data : issue;
					end
				end
				issue: begin
					if (!job_start) begin
						state     <= idle;
						issue_idx <= '0;
					end else if (last_issue) begin
						state <= wait_data;
					end
				end
				wait_data: begin
					// descriptor withdrawn ends the job
					if (!job_start) begin
						state     <= idle;
						issue_idx <= '0;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	////////////////////
	// returned data
	////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			data_q <= '0;
		end else if (enabled) begin
			data_q <= read_data_in;
		end else begin
			data_q.valid <= 1'b0;
		end
	end

	// only lines that carry our id
	assign data_hit = data_q.valid && (data_q.cmd.cu_id == VERTEX_CONTROL_ID);

	// first vertex of the line from the echoed address
	assign line_offset  = data_q.cmd.address - wed.vertex_base;
	assign first_vertex = vertex_cnt_t'(line_offset >> LINE_SHIFT) << VPL_SHIFT;

	// lane 0 sits in the low 16 bits, tail lanes past num_vertices skipped
	always_comb begin
		line_processed = '0;
		line_filtered  = '0;
		line_edges     = '0;
		lane_degree    = '0;
		for (int lane = 0; lane < VERTICES_PER_LINE; lane++) begin
			lane_degree = data_q.data[lane*DEGREE_W +: DEGREE_W];
			if (first_vertex + vertex_cnt_t'(lane) < wed.num_vertices) begin
				if (lane_degree != '0) begin
					line_processed = line_processed + 1'b1;
				end else begin
					line_filtered = line_filtered + 1'b1;
				end
				line_edges = line_edges + edge_cnt_t'(lane_degree);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_count   <= '0;
			filtered_count <= '0;
			edge_count     <= '0;
		end else if (state == idle && enabled && job_start) begin
			// fresh totals for a new job
			vertex_count   <= '0;
			filtered_count <= '0;
			edge_count     <= '0;
		end else if (data_hit && state != idle) begin
			vertex_count   <= vertex_count + line_processed;
			filtered_count <= filtered_count + line_filtered;
			edge_count     <= edge_count + line_edges;
		end
	end

	// every push was decided in a cycle with headroom in the buffer
	a_push_after_room: assert property (@(posedge clock) disable iff (!rstn)
		cmd_out.valid |-> !$past(fifo_alfull));

endmodule

`default_nettype wire

/* design/command_fifo.sv */
////////////////////
// circular command buffer with first-word-fall-through output
// almost-full raised once free slots drop to HEADROOM
////////////////////

`default_nettype none

module command_fifo #(
	parameter int WIDTH    = 8,
	parameter int DEPTH    = 16,
	parameter int HEADROOM = 8
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        push,
	input  logic [WIDTH-1:0]            data_in,
	input  logic                        pop,
	output logic [WIDTH-1:0]            data_out,
	output host_if_pkg::buffer_status_t status
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// guarded strobes keep the pointers sane on a bad request
	assign do_push = push && !status.full;
	assign do_pop  = pop && !status.empty;

	// payload storage
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// occupancy only moves when exactly one side fires
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// head entry visible without a pop
	assign data_out = mem[rd_ptr];

	assign status.full   = (count == CNT_W'(DEPTH));
	assign status.empty  = (count == '0);
	assign status.valid  = (count != '0);
	assign status.alfull = ((CNT_W'(DEPTH) - count) <= CNT_W'(HEADROOM));

	////////////////////
	// protocol checks
	////////////////////
	// producer must have backed off at almost-full long before this
	a_no_push_full: assert property (@(posedge clock) disable iff (!rstn)
		status.full |-> !push);

	a_no_pop_empty: assert property (@(posedge clock) disable iff (!rstn)
		status.empty |-> !pop);

endmodule

`default_nettype wire

/* design/graph_pkg.sv */
////////////////////
// graph job types: work descriptor, counter widths, return words, unit id
////////////////////

`default_nettype none

package graph_pkg;

	// vertex and edge totals
	typedef logic [31:0] vertex_cnt_t;
	typedef logic [31:0] edge_cnt_t;

	// one out-degree in the vertex array
	typedef logic [15:0] degree_t;

	// configuration and status word
	typedef logic [63:0] cu_config_t;

	// out-degrees packed into one data line
	localparam int VERTICES_PER_LINE = 8;

	// id stamped on the vertex reader's commands
	localparam host_if_pkg::cu_id_t VERTEX_CONTROL_ID = 8'd1;

	////////////////////
	// work descriptor
	////////////////////
	typedef struct packed {
		logic                valid;
		vertex_cnt_t         num_vertices;
		edge_cnt_t           num_edges;
		host_if_pkg::addr_t  vertex_base;
	} wed_t;

	// var1 holds vertices seen, var2 the edge sum
	typedef struct packed {
		logic [63:0] var1;
		logic [63:0] var2;
	} cu_return_t;

endpackage

`default_nettype wire

/* design/host_if_pkg.sv */
////////////////////
// host memory interface types: read commands, data lines, buffer flags
// imported by every block that talks to the cache-line read port
////////////////////

`default_nettype none

package host_if_pkg;

	// byte address into shared memory
	typedef logic [63:0] addr_t;

	// id of the requesting unit, echoed back with the data
	typedef logic [7:0] cu_id_t;

	// byte count of one request
	typedef logic [7:0] cmd_size_t;

	// payload of one returned data line
	typedef logic [127:0] line_data_t;

	// bytes carried by one data line
	localparam int LINE_BYTES = 16;

	////////////////////
	// read command
	////////////////////
	typedef struct packed {
		logic      valid;
		cu_id_t    cu_id;
		addr_t     address;
		cmd_size_t size;
	} read_cmd_t;

	// returned line, command echoed so the owner can place it
	typedef struct packed {
		logic       valid;
		read_cmd_t  cmd;
		line_data_t data;
	} data_line_t;

	// occupancy flags of a buffer
	typedef struct packed {
		logic full;
		logic alfull;
		logic valid;
		logic empty;
	} buffer_status_t;

endpackage

`default_nettype wire
